/* Bender.yml */
package:
  name: video_gen

sources:
  - include_dirs:
      - common
    files:
      - common/video_pkg.sv
      - rtl/video_timing.sv
      - rtl/video_regs.sv
      - playfield/fetch_ctrl.sv
      - playfield/pixel_out.sv
      - rtl/video_gen.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock.sv
      - tests/tb_video_gen.sv

/* common/video_consts.svh */
// video generator constants
// tiny raster geometry, fetch timing and register numbers
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// raster geometry, the blanked part comes first on each line
`define VID_H_OFFSCREEN     8
`define VID_H_VISIBLE       16
`define VID_H_TOTAL         24
`define VID_H_SYNC_START    2           // short front porch
`define VID_H_SYNC_END      5           // 3 cycle hsync
`define VID_V_VISIBLE       4
`define VID_V_TOTAL         7
`define VID_V_SYNC_LINE     5

`define VID_FETCH_LEAD      6           // cycles before first pixel
`define VID_FIFO_DEPTH      4           // words

// register numbers
`define XR_VID_CTRL         6'h00
`define XR_SCANLINE         6'h02       // read only
`define XR_VID_LEFT         6'h03
`define XR_VID_RIGHT        6'h04
`define XR_PA_GFX_CTRL      6'h10
`define XR_PA_DISP_ADDR     6'h12
`define XR_PA_LINE_LEN      6'h13

`endif

/* common/video_pkg.sv */
// video generator package
// shared vector types, fetch states and configuration structs
package video_pkg;

    typedef logic [15:0] word_t;        // register and memory data
    typedef logic [15:0] addr_t;        // video RAM word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [4:0]  hres_t;
    typedef logic [2:0]  vres_t;
    typedef logic [5:0]  reg_num_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_HOLD
    } fetch_state_t;

    // current raster position and flags
    typedef struct packed {
        hres_t  h_count;
        vres_t  v_count;
        logic   h_visible;
        logic   v_visible;
        logic   hsync;
        logic   vsync;
    } raster_t;

    // playfield A and border settings
    typedef struct packed {
        color_t border_color;
        word_t  vid_left;               // first windowed pixel
        word_t  vid_right;              // first border pixel after window
        color_t colorbase;
        logic   blank;
        addr_t  start_addr;
        word_t  line_len;               // words added per line
    } pf_cfg_t;

endpackage

/* playfield/fetch_ctrl.sv */
// playfield fetch controller
// FSM issuing video RAM reads for each visible line with FIFO
// back-pressure, plus the per-line address stepping
`timescale 1ns/1ps
`include "video_consts.svh"

module fetch_ctrl (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire video_pkg::raster_t                 raster_i,
    input  wire logic                               end_of_line_i,
    input  wire logic                               end_of_frame_i,
    input  wire video_pkg::pf_cfg_t                 pf_cfg_i,
    input  wire logic [$clog2(`VID_FIFO_DEPTH):0]   fifo_level_i,
    output logic                                    vram_sel_o,
    output video_pkg::addr_t                        vram_addr_o,
    output logic                                    word_valid_o
);
    import video_pkg::*;

    localparam int LINE_WORDS = `VID_H_VISIBLE / 2;
    localparam int LEVEL_W    = $clog2(`VID_FIFO_DEPTH) + 1;

    fetch_state_t                   state;
    fetch_state_t                   state_next;
    logic [$clog2(LINE_WORDS)-1:0]  word_cnt;
    addr_t                          line_addr;
    word_t                          line_len;       // latched per frame
    logic                           frame_blank;    // latched per frame
    logic                           fetch_start;
    logic [LEVEL_W-1:0]             committed;      // words in FIFO or in flight

    always_comb begin
        committed   = fifo_level_i + LEVEL_W'(word_valid_o);
        fetch_start = raster_i.v_visible && !frame_blank &&
                      (raster_i.h_count == hres_t'(`VID_H_OFFSCREEN - `VID_FETCH_LEAD));
        state_next  = state;
        case (state)
            FETCH_IDLE: begin
                if (fetch_start) begin
                    state_next = FETCH_READ;
                end
            end
            FETCH_READ: begin
                if (word_cnt == ($bits(word_cnt))'(LINE_WORDS - 1)) begin
                    state_next = FETCH_IDLE;
                end else if (committed >= LEVEL_W'(`VID_FIFO_DEPTH - 1)) begin
                    state_next = FETCH_HOLD;        // this read fills the FIFO
                end
            end
            FETCH_HOLD: begin
                if (committed < LEVEL_W'(`VID_FIFO_DEPTH)) begin
                    state_next = FETCH_READ;
                end
            end
            default: state_next = FETCH_IDLE;
        endcase
    end

    assign vram_sel_o  = (state == FETCH_READ);
    assign vram_addr_o = line_addr + addr_t'(word_cnt);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= FETCH_IDLE;
            word_cnt     <= '0;
            word_valid_o <= 1'b0;
            line_addr    <= '0;
            line_len     <= word_t'(LINE_WORDS);
            frame_blank  <= 1'b1;
        end else begin
            state        <= state_next;
            word_valid_o <= vram_sel_o;             // data lands next cycle
            if (vram_sel_o) begin
                word_cnt <= (state_next == FETCH_IDLE) ? '0 : word_cnt + 1'b1;
            end
            // new settings only take hold at a frame boundary
            if (end_of_frame_i) begin
                line_addr   <= pf_cfg_i.start_addr;
                line_len    <= pf_cfg_i.line_len;
                frame_blank <= pf_cfg_i.blank;
            end else if (end_of_line_i && raster_i.v_visible) begin
                line_addr   <= line_addr + line_len;    // wraps at 64K
            end
        end
    end

endmodule

/* playfield/pixel_out.sv */
// pixel output stage
// word FIFO, byte unpacking, border window and colorbase, with all
// video outputs registered together
`timescale 1ns/1ps
`include "video_consts.svh"

module pixel_out (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire video_pkg::raster_t                 raster_i,
    input  wire video_pkg::pf_cfg_t                 pf_cfg_i,
    input  wire logic                               word_valid_i,
    input  wire video_pkg::word_t                   vram_data_i,
    output logic [$clog2(`VID_FIFO_DEPTH):0]        fifo_level_o,
    output video_pkg::color_t                       colorA_index_o,
    output logic                                    h_blank_o,
    output logic                                    v_blank_o,
    output logic                                    hsync_o,
    output logic                                    vsync_o,
    output logic                                    dv_de_o
);
    import video_pkg::*;

    localparam int PTR_W   = $clog2(`VID_FIFO_DEPTH);
    localparam int LEVEL_W = PTR_W + 1;

    word_t              fifo_mem [`VID_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               frame_blank;    // matches the fetch side
    logic               frame_end;
    logic               visible;
    logic               pop;
    logic               in_window;
    hres_t              x_pos;
    color_t             pf_byte;
    color_t             color_next;

    always_comb begin
        visible   = raster_i.h_visible && raster_i.v_visible;
        frame_end = (raster_i.h_count == hres_t'(`VID_H_TOTAL - 1)) &&
                    (raster_i.v_count == vres_t'(`VID_V_TOTAL - 1));
        x_pos     = raster_i.h_count - hres_t'(`VID_H_OFFSCREEN);
        in_window = (word_t'(x_pos) >= pf_cfg_i.vid_left) &&
                    (word_t'(x_pos) < pf_cfg_i.vid_right);
        pf_byte   = x_pos[0] ? fifo_mem[rd_ptr][7:0] : fifo_mem[rd_ptr][15:8];
        pop       = visible && !frame_blank && x_pos[0] && (fifo_level_o != '0);

        if (!visible) begin
            color_next = '0;
        end else if (frame_blank || !in_window) begin
            color_next = pf_cfg_i.border_color;     // border skips colorbase
        end else begin
            color_next = pf_byte ^ pf_cfg_i.colorbase;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid_i) begin
            fifo_mem[wr_ptr] <= vram_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_level_o   <= '0;
            frame_blank    <= 1'b1;
            colorA_index_o <= '0;
            h_blank_o      <= 1'b1;
            v_blank_o      <= 1'b1;
            hsync_o        <= 1'b0;
            vsync_o        <= 1'b0;
            dv_de_o        <= 1'b0;
        end else begin
            if (word_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;            // word done after low byte
            end
            fifo_level_o <= fifo_level_o + LEVEL_W'(word_valid_i) - LEVEL_W'(pop);
            if (frame_end) begin
                frame_blank <= pf_cfg_i.blank;
            end
            colorA_index_o <= color_next;
            h_blank_o      <= !raster_i.h_visible;
            v_blank_o      <= !raster_i.v_visible;
            hsync_o        <= raster_i.hsync;
            vsync_o        <= raster_i.vsync;
            dv_de_o        <= visible;
        end
    end

endmodule

/* rtl/video_gen.sv */
// bitmap video generator top level
// connects timing, registers, fetch controller and pixel output
`timescale 1ns/1ps
`include "video_consts.svh"

module video_gen (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   vgen_reg_wr_en_i,
    input  wire video_pkg::reg_num_t    vgen_reg_num_i,
    input  wire video_pkg::word_t       vgen_reg_data_i,
    output video_pkg::word_t            vgen_reg_data_o,
    output logic                        video_intr_o,
    output logic                        vram_sel_o,
    output video_pkg::addr_t            vram_addr_o,
    input  wire video_pkg::word_t       vram_data_i,
    output video_pkg::color_t           colorA_index_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);
    import video_pkg::*;

    raster_t                            raster;
    pf_cfg_t                            pf_cfg;
    logic                               end_of_line;
    logic                               end_of_frame;
    logic                               end_of_visible;
    logic                               word_valid;     // vram_data_i holds a word
    logic [$clog2(`VID_FIFO_DEPTH):0]   fifo_level;

    video_timing video_timing_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .raster_o         (raster),
        .end_of_line_o    (end_of_line),
        .end_of_frame_o   (end_of_frame),
        .end_of_visible_o (end_of_visible)
    );

    video_regs video_regs_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .vgen_reg_wr_en_i (vgen_reg_wr_en_i),
        .vgen_reg_num_i   (vgen_reg_num_i),
        .vgen_reg_data_i  (vgen_reg_data_i),
        .vgen_reg_data_o  (vgen_reg_data_o),
        .v_count_i        (raster.v_count),
        .end_of_visible_i (end_of_visible),
        .pf_cfg_o         (pf_cfg),
        .video_intr_o     (video_intr_o)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .raster_i         (raster),
        .end_of_line_i    (end_of_line),
        .end_of_frame_i   (end_of_frame),
        .pf_cfg_i         (pf_cfg),
        .fifo_level_i     (fifo_level),
        .vram_sel_o       (vram_sel_o),
        .vram_addr_o      (vram_addr_o),
        .word_valid_o     (word_valid)
    );

    pixel_out pixel_out_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .raster_i         (raster),
        .pf_cfg_i         (pf_cfg),
        .word_valid_i     (word_valid),
        .vram_data_i      (vram_data_i),
        .fifo_level_o     (fifo_level),
        .colorA_index_o   (colorA_index_o),
        .h_blank_o        (h_blank_o),
        .v_blank_o        (v_blank_o),
        .hsync_o          (hsync_o),
        .vsync_o          (vsync_o),
        .dv_de_o          (dv_de_o)
    );

endmodule

/* rtl/video_regs.sv */
// video registers
// write decode into the playfield settings, registered readback
// and the end of visible interrupt pulse
`timescale 1ns/1ps
`include "video_consts.svh"

module video_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   vgen_reg_wr_en_i,
    input  wire video_pkg::reg_num_t    vgen_reg_num_i,
    input  wire video_pkg::word_t       vgen_reg_data_i,
    output video_pkg::word_t            vgen_reg_data_o,
    input  wire video_pkg::vres_t       v_count_i,
    input  wire logic                   end_of_visible_i,
    output video_pkg::pf_cfg_t          pf_cfg_o,
    output logic                        video_intr_o
);
    import video_pkg::*;

    word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pf_cfg_o.border_color <= 8'h08;             // grey border shows life
            pf_cfg_o.vid_left     <= '0;
            pf_cfg_o.vid_right    <= word_t'(`VID_H_VISIBLE);
            pf_cfg_o.colorbase    <= '0;
            pf_cfg_o.blank        <= 1'b1;              // playfield off
            pf_cfg_o.start_addr   <= '0;
            pf_cfg_o.line_len     <= word_t'(`VID_H_VISIBLE / 2);
            video_intr_o          <= 1'b0;
        end else begin
            video_intr_o <= end_of_visible_i;
            if (vgen_reg_wr_en_i) begin
                case (vgen_reg_num_i)
                    `XR_VID_CTRL: begin
                        pf_cfg_o.border_color <= vgen_reg_data_i[7:0];
                    end
                    `XR_VID_LEFT: begin
                        pf_cfg_o.vid_left <= vgen_reg_data_i;
                    end
                    `XR_VID_RIGHT: begin
                        pf_cfg_o.vid_right <= vgen_reg_data_i;
                    end
                    `XR_PA_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= vgen_reg_data_i[15:8];
                        pf_cfg_o.blank     <= vgen_reg_data_i[7];
                    end
                    `XR_PA_DISP_ADDR: begin
                        pf_cfg_o.start_addr <= vgen_reg_data_i;
                    end
                    `XR_PA_LINE_LEN: begin
                        pf_cfg_o.line_len <= vgen_reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (vgen_reg_num_i)
            `XR_VID_CTRL:     rd_data = {8'h00, pf_cfg_o.border_color};
            `XR_SCANLINE:     rd_data = word_t'(v_count_i);       // live line count
            `XR_VID_LEFT:     rd_data = pf_cfg_o.vid_left;
            `XR_VID_RIGHT:    rd_data = pf_cfg_o.vid_right;
            `XR_PA_GFX_CTRL:  rd_data = {pf_cfg_o.colorbase, pf_cfg_o.blank, 7'b0};
            `XR_PA_DISP_ADDR: rd_data = pf_cfg_o.start_addr;
            `XR_PA_LINE_LEN:  rd_data = pf_cfg_o.line_len;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        vgen_reg_data_o <= rd_data;
    end

endmodule

/* rtl/video_timing.sv */
// video timing
// pixel and line counters with visible flags, syncs and the
// line, frame and end of visible strobes
`timescale 1ns/1ps
`include "video_consts.svh"

module video_timing (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output video_pkg::raster_t  raster_o,
    output logic                end_of_line_o,
    output logic                end_of_frame_o,
    output logic                end_of_visible_o
);
    import video_pkg::*;

    hres_t  h_next;
    vres_t  v_next;
    logic   line_last;
    logic   next_last;                  // next cycle ends a line

    always_comb begin
        line_last = (raster_o.h_count == hres_t'(`VID_H_TOTAL - 1));
        h_next    = line_last ? '0 : raster_o.h_count + 1'b1;
        v_next    = raster_o.v_count;
        if (line_last) begin
            if (raster_o.v_count == vres_t'(`VID_V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = raster_o.v_count + 1'b1;
            end
        end
        next_last = (h_next == hres_t'(`VID_H_TOTAL - 1));
    end

    // flags come from the next counts so all outputs line up
    always_ff @(posedge clk) begin
        if (reset_i) begin
            raster_o         <= '{h_count: '0, v_count: '0, h_visible: 1'b0,
                                  v_visible: 1'b1, hsync: 1'b0, vsync: 1'b0};
            end_of_line_o    <= 1'b0;
            end_of_frame_o   <= 1'b0;
            end_of_visible_o <= 1'b0;
        end else begin
            raster_o.h_count   <= h_next;
            raster_o.v_count   <= v_next;
            raster_o.h_visible <= (h_next >= hres_t'(`VID_H_OFFSCREEN));
            raster_o.v_visible <= (v_next < vres_t'(`VID_V_VISIBLE));
            raster_o.hsync     <= (h_next >= hres_t'(`VID_H_SYNC_START)) &&
                                  (h_next < hres_t'(`VID_H_SYNC_END));
            raster_o.vsync     <= (v_next == vres_t'(`VID_V_SYNC_LINE));
            end_of_line_o      <= next_last;
            end_of_frame_o     <= next_last && (v_next == vres_t'(`VID_V_TOTAL - 1));
            end_of_visible_o   <= next_last && (v_next == vres_t'(`VID_V_VISIBLE - 1));
        end
    end

endmodule

/* tb.f */
+incdir+common
common/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
playfield/fetch_ctrl.sv
playfield/pixel_out.sv
rtl/video_gen.sv
tests/tb_clock.sv
tests/tb_video_gen.sv

/* tests/tb_clock.sv */
// testbench clock and reset
// 10 ns clock, reset held high for the first 3 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_o = 1'b0;                 // released on a falling edge
    end

endmodule

/* tests/tb_video_gen.sv */
// video generator testbench
// directed tests of reset values, bitmap display, border window, line
// stepping and register readback, with a video RAM model
`timescale 1ns/1ps
`include "video_consts.svh"

module tb_video_gen;
    import video_pkg::*;

    localparam int          FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int          WAIT_LIMIT   = 3 * FRAME_CYCLES;
    localparam logic [31:0] LFSR_SEED    = 32'd94785;
    localparam int          HSYNC_CYCLES = 3;           // per line
    localparam int          VSYNC_LINE   = 5;

    logic       clk;
    logic       reset_i;
    logic       vgen_reg_wr_en_i;
    reg_num_t   vgen_reg_num_i;
    word_t      vgen_reg_data_i;
    word_t      vgen_reg_data_o;
    logic       video_intr_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i;
    color_t     colorA_index_o;
    logic       h_blank_o;
    logic       v_blank_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    word_t      vram_mem [65536];
    logic       rd_pending;             // read seen on the last falling edge
    addr_t      rd_addr;
    pf_cfg_t    exp_cfg;                // settings the DUT should hold

    tb_clock clock_gen_i (
        .clk     (clk),
        .reset_o (reset_i)
    );

    video_gen dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .vgen_reg_wr_en_i (vgen_reg_wr_en_i),
        .vgen_reg_num_i   (vgen_reg_num_i),
        .vgen_reg_data_i  (vgen_reg_data_i),
        .vgen_reg_data_o  (vgen_reg_data_o),
        .video_intr_o     (video_intr_o),
        .vram_sel_o       (vram_sel_o),
        .vram_addr_o      (vram_addr_o),
        .vram_data_i      (vram_data_i),
        .colorA_index_o   (colorA_index_o),
        .h_blank_o        (h_blank_o),
        .v_blank_o        (v_blank_o),
        .hsync_o          (hsync_o),
        .vsync_o          (vsync_o),
        .dv_de_o          (dv_de_o)
    );

    // video RAM, data shows up in the cycle after the request
    always @(negedge clk) begin
        if (rd_pending) begin
            vram_data_i = vram_mem[rd_addr];
        end
        rd_pending = vram_sel_o;
        rd_addr    = vram_addr_o;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic fill_vram();
        logic [31:0] lfsr;
        word_t       w;
        int          a;
        int          b;
        lfsr = LFSR_SEED;
        w    = '0;
        for (a = 0; a < 65536; a++) begin
            for (b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);
                w    = {w[14:0], lfsr[0]};  // one step per bit
            end
            vram_mem[a] = w;
        end
    endtask

    // pixel x on visible line y
    function automatic color_t expected_pixel(input int x, input int y);
        addr_t addr;
        word_t data;
        if (exp_cfg.blank || x < exp_cfg.vid_left || x >= exp_cfg.vid_right) begin
            return exp_cfg.border_color;
        end
        addr = addr_t'(exp_cfg.start_addr + y * exp_cfg.line_len + x / 2);   // mod 64K
        data = vram_mem[addr];
        return ((x % 2 == 0) ? data[15:8] : data[7:0]) ^ exp_cfg.colorbase;
    endfunction

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("error at %0d ns: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic reg_write(input reg_num_t num, input word_t data);
        @(negedge clk);
        vgen_reg_wr_en_i = 1'b1;
        vgen_reg_num_i   = num;
        vgen_reg_data_i  = data;
        @(negedge clk);
        vgen_reg_wr_en_i = 1'b0;
    endtask

    task automatic reg_read(input reg_num_t num, output word_t data);
        @(negedge clk);
        vgen_reg_num_i = num;
        @(negedge clk);
        data = vgen_reg_data_o;         // registered readback
    endtask

    task automatic check_reg(input reg_num_t num, input word_t exp, input string what);
        word_t value;
        reg_read(num, value);
        check_word(value, exp, what);
    endtask

    task automatic wait_frame();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_failure("timeout waiting for the end of visible interrupt");
            end
        end while (!video_intr_o);
    endtask

    // written in vertical blanking, so the next frame uses all of it
    task automatic apply_settings(input color_t border, input word_t left,
                                  input word_t right, input color_t cbase,
                                  input logic blank, input addr_t start,
                                  input word_t len);
        reg_write(`XR_VID_CTRL, {8'h00, border});
        reg_write(`XR_VID_LEFT, left);
        reg_write(`XR_VID_RIGHT, right);
        reg_write(`XR_PA_GFX_CTRL, {cbase, blank, 7'b0});
        reg_write(`XR_PA_DISP_ADDR, start);
        reg_write(`XR_PA_LINE_LEN, len);
        exp_cfg.border_color = border;
        exp_cfg.vid_left     = left;
        exp_cfg.vid_right    = right;
        exp_cfg.colorbase    = cbase;
        exp_cfg.blank        = blank;
        exp_cfg.start_addr   = start;
        exp_cfg.line_len     = len;
    endtask

    task automatic check_frame();
        int cycles;
        int x;
        int y;
        cycles = 0;
        x      = 0;
        y      = 0;
        while (!v_blank_o) begin        // start counting from line 0
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_failure("timeout waiting for vertical blanking");
            end
        end
        while (y < `VID_V_VISIBLE) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_failure("timeout while checking the pixels of a frame");
            end
            if (!h_blank_o && !v_blank_o) begin
                check_flag(dv_de_o, 1'b1, "dv_de_o in the visible area");
                check_color(colorA_index_o, expected_pixel(x, y),
                            $sformatf("pixel x=%0d y=%0d", x, y));
                x++;
            end else begin
                check_flag(dv_de_o, 1'b0, "dv_de_o in blanking");
                check_color(colorA_index_o, 8'h00, "color in blanking");
                if (x != 0) begin
                    check_word(word_t'(x), word_t'(`VID_H_VISIBLE), "pixels per line");
                    x = 0;
                    y++;
                end
            end
        end
    endtask

    // one whole frame of sync outputs, starting on the first blanked line
    task automatic check_syncs();
        int   line;
        int   hsync_cycles;
        logic h_blank_last;
        wait_frame();                   // outputs still show the last visible pixel
        line         = `VID_V_VISIBLE - 1;
        hsync_cycles = 0;
        h_blank_last = h_blank_o;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (h_blank_o && !h_blank_last) begin
                line = (line + 1) % `VID_V_TOTAL;   // a new line starts blanked
            end
            h_blank_last = h_blank_o;
            if (hsync_o) begin
                check_flag(h_blank_o, 1'b1, "h_blank_o during hsync");
                hsync_cycles++;
            end
            check_flag(vsync_o, line == VSYNC_LINE,
                       $sformatf("vsync_o on line %0d", line));
        end
        check_word(word_t'(hsync_cycles), word_t'(HSYNC_CYCLES * `VID_V_TOTAL),
                   "hsync cycles in a frame");
    endtask

    task automatic test_reset_values();
        word_t value;
        check_reg(`XR_VID_CTRL, 16'h0008, "VID_CTRL after reset");
        check_reg(`XR_VID_LEFT, 16'h0000, "VID_LEFT after reset");
        check_reg(`XR_VID_RIGHT, word_t'(`VID_H_VISIBLE), "VID_RIGHT after reset");
        check_reg(`XR_PA_GFX_CTRL, 16'h0080, "PA_GFX_CTRL after reset");
        check_reg(`XR_PA_DISP_ADDR, 16'h0000, "PA_DISP_ADDR after reset");
        check_reg(`XR_PA_LINE_LEN, word_t'(`VID_H_VISIBLE / 2), "PA_LINE_LEN after reset");
        reg_read(`XR_SCANLINE, value);
        check_flag(value < `VID_V_TOTAL, 1'b1, "SCANLINE within the frame");
        wait_frame();
        check_frame();                  // blanked, all border
        check_syncs();
    endtask

    task automatic test_bitmap_display();
        wait_frame();
        apply_settings(8'h08, 16'd0, 16'd16, 8'h00, 1'b0, 16'h2468, 16'h0008);
        check_frame();
    endtask

    task automatic test_border_window();
        wait_frame();
        apply_settings(8'h21, 16'd4, 16'd12, 8'h5A, 1'b0, 16'h0100, 16'h0008);
        check_frame();
    endtask

    task automatic test_line_wrap();
        wait_frame();
        // first line wraps inside itself, later lines start past zero
        apply_settings(8'h33, 16'd0, 16'd16, 8'h00, 1'b0, 16'hFFFA, 16'h0014);
        check_frame();
    endtask

    task automatic test_readback_scanline();
        word_t value;
        int    cycles;
        reg_write(`XR_VID_CTRL, 16'hABC3);
        check_reg(`XR_VID_CTRL, 16'h00C3, "VID_CTRL readback");
        reg_write(`XR_VID_LEFT, 16'h1234);
        check_reg(`XR_VID_LEFT, 16'h1234, "VID_LEFT readback");
        reg_write(`XR_VID_RIGHT, 16'h00FE);
        check_reg(`XR_VID_RIGHT, 16'h00FE, "VID_RIGHT readback");
        reg_write(`XR_PA_GFX_CTRL, 16'h3CFF);
        check_reg(`XR_PA_GFX_CTRL, 16'h3C80, "PA_GFX_CTRL readback");
        reg_write(`XR_PA_DISP_ADDR, 16'hBEEF);
        check_reg(`XR_PA_DISP_ADDR, 16'hBEEF, "PA_DISP_ADDR readback");
        reg_write(`XR_PA_LINE_LEN, 16'h0055);
        check_reg(`XR_PA_LINE_LEN, 16'h0055, "PA_LINE_LEN readback");
        check_reg(6'h3F, 16'h0000, "unused register readback");
        wait_frame();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_failure("timeout waiting for the next frame interrupt");
            end
        end while (!video_intr_o);
        check_word(word_t'(cycles), word_t'(FRAME_CYCLES), "cycles between interrupts");
        reg_read(`XR_SCANLINE, value);
        check_flag((value >= `VID_V_VISIBLE - 1) && (value < `VID_V_TOTAL), 1'b1,
                   "SCANLINE right after the interrupt");
    endtask

    initial begin
        int cycles;
        vgen_reg_wr_en_i = 1'b0;
        vgen_reg_num_i   = '0;
        vgen_reg_data_i  = '0;
        vram_data_i      = '0;
        rd_pending       = 1'b0;
        rd_addr          = '0;
        exp_cfg          = '{border_color: 8'h08, vid_left: 16'd0,
                             vid_right: word_t'(`VID_H_VISIBLE), colorbase: 8'h00,
                             blank: 1'b1, start_addr: 16'h0000,
                             line_len: word_t'(`VID_H_VISIBLE / 2)};
        fill_vram();
        cycles = 0;
        while (reset_i !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_failure("timeout waiting for reset to be released");
            end
        end
        test_reset_values();
        test_bitmap_display();
        test_border_window();
        test_line_wrap();
        test_readback_scanline();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
